// ==== project.f ====
rtl/eth_xgmii_pkg.sv
rtl/eth_mac_pkg.sv
rtl/mac_stream_if.sv
rtl/tx_pause_gate.sv
rtl/xgmii_tx_32.sv
rtl/xgmii_rx_32.sv
rtl/eth_mac_32.sv
bench/eth_mac_checker.sv
bench/eth_mac_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module eth_mac_tb -f project.f -o eth_mac_sim
./obj_dir/eth_mac_sim

// ==== bench/eth_mac_tb.sv ====
// Loopback and bench-driven XGMII tests; every wait gives up after TIMEOUT cycles.
module eth_mac_tb;

localparam int TIMEOUT = 200;

logic clk;
logic rst;
logic [31:0] tx_axis_tdata;
logic [3:0] tx_axis_tkeep;
logic tx_axis_tvalid;
logic tx_axis_tready;
logic tx_axis_tlast;
logic [31:0] rx_axis_tdata;
logic [3:0] rx_axis_tkeep;
logic rx_axis_tvalid;
logic rx_axis_tlast;
logic rx_axis_tuser;
logic [31:0] xgmii_txd;
logic [3:0] xgmii_txc;
logic [31:0] xgmii_rxd;
logic [3:0] xgmii_rxc;
logic tx_pause_req;
logic tx_pause_ack;
logic tx_start_packet;
logic stat_tx_pkt_good;
logic stat_tx_err_underflow;
logic rx_start_packet;
logic stat_rx_pkt_good;
logic stat_rx_pkt_bad;
logic stat_rx_err_preamble;

// receive side fed from txd in loopback, else from bench words.
logic loop_sel;
logic [31:0] drv_rxd;
logic [3:0] drv_rxc;
logic accepted;
logic [31:0] lfsr_state;
logic [7:0] frame_buf [0:67];
logic [7:0] exp_bytes [$];
int exp_lens [$];
logic exp_bad [$];
int rx_pos = 0;
int good_cnt = 0;
int bad_cnt = 0;
int underflow_cnt = 0;
int preamble_cnt = 0;
int tx_start_cnt = 0;
int tx_good_cnt = 0;
int rx_start_cnt = 0;

assign xgmii_rxd = loop_sel ? xgmii_txd : drv_rxd;
assign xgmii_rxc = loop_sel ? xgmii_txc : drv_rxc;

eth_mac_32 dut0 (.*);

bind eth_mac_32 eth_mac_checker checker0 (
    .clk(clk),
    .rst(rst),
    .tx_axis_tready(tx_axis_tready),
    .tx_pause_ack(tx_pause_ack),
    .xgmii_txd(xgmii_txd),
    .xgmii_txc(xgmii_txc),
    .rx_axis_tvalid(rx_axis_tvalid),
    .rx_axis_tlast(rx_axis_tlast),
    .rx_axis_tuser(rx_axis_tuser)
);

initial begin
    clk = 1'b0;
    forever begin
        #10 clk = ~clk;
    end
end

// transfer seen at the last rising edge.
always @(posedge clk) begin
    accepted <= tx_axis_tvalid && tx_axis_tready;
end

// ====================
// helpers
// ====================

task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
endtask

// galois lfsr stepped once per bit taken.
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return val;
endfunction

// bytes delivered are all data, or data up to the stall plus one error word.
function automatic int ref_len(input int len, input int stall);
    return (stall < 0) ? len : 4 * stall + 4;
endfunction

function automatic logic [7:0] ref_byte(input int idx, input int stall);
    if (stall >= 0 && idx >= 4 * stall) begin
        return eth_xgmii_pkg::XGMII_ERROR;
    end
    return frame_buf[idx];
endfunction

// end flag and keep for a beat with remaining bytes left in the frame.
function automatic logic [4:0] ref_beat(input int remaining);
    if (remaining > 4) begin
        return {1'b0, 4'hf};
    end
    return {1'b1, 4'((1 << remaining) - 1)};
endfunction

task automatic fill_frame(input int len);
    for (int i = 0; i < len; i++) begin
        frame_buf[i] = 8'(lfsr_bits(8));
    end
endtask

task automatic push_expected(input int len, input int stall);
    for (int i = 0; i < ref_len(len, stall); i++) begin
        exp_bytes.push_back(ref_byte(i, stall));
    end
    exp_lens.push_back(ref_len(len, stall));
    exp_bad.push_back(stall >= 0);
endtask

// stall >= 1 drops tvalid for one cycle before that beat.
task automatic send_frame(input int len, input int stall);
    int nb;
    int cnt;
    fill_frame(len);
    push_expected(len, stall);
    nb = (len + 3) / 4;
    for (int b = 0; b < nb; b++) begin
        if (b == stall) begin
            tx_axis_tvalid = 1'b0;
            @(negedge clk);
        end
        for (int i = 0; i < 4; i++) begin
            tx_axis_tdata[8*i +: 8] = (4 * b + i < len) ? frame_buf[4 * b + i] : 8'h00;
            tx_axis_tkeep[i] = (4 * b + i < len);
        end
        tx_axis_tlast = (b == nb - 1);
        tx_axis_tvalid = 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!accepted && cnt < TIMEOUT);
        if (!accepted) begin
            stop_run("transmit beat was not accepted before the timeout");
        end
    end
    tx_axis_tvalid = 1'b0;
    tx_axis_tlast = 1'b0;
endtask

task automatic drive_rx_word(input logic [31:0] d, input logic [3:0] c);
    drv_rxd = d;
    drv_rxc = c;
    @(negedge clk);
endtask

// start, preamble with the given sfd, data, terminate after the last byte.
task automatic drive_rx_frame(input int len, input logic [7:0] sfd);
    logic [31:0] d;
    logic [3:0] c;
    int pos;
    fill_frame(len);
    if (sfd == eth_xgmii_pkg::ETH_SFD) begin
        push_expected(len, -1);
    end
    drive_rx_word({{3{eth_xgmii_pkg::ETH_PRE}}, eth_xgmii_pkg::XGMII_START}, 4'b0001);
    drive_rx_word({sfd, {3{eth_xgmii_pkg::ETH_PRE}}}, 4'b0000);
    for (int w = 0; w <= len / 4; w++) begin
        for (int i = 0; i < 4; i++) begin
            pos = 4 * w + i;
            c[i] = (pos >= len);
            if (pos < len) begin
                d[8*i +: 8] = frame_buf[pos];
            end else if (pos == len) begin
                d[8*i +: 8] = eth_xgmii_pkg::XGMII_TERM;
            end else begin
                d[8*i +: 8] = eth_xgmii_pkg::XGMII_IDLE;
            end
        end
        drive_rx_word(d, c);
    end
    repeat (4) begin
        drive_rx_word({4{eth_xgmii_pkg::XGMII_IDLE}}, 4'hf);
    end
endtask

task automatic wait_rx_done();
    int cnt;
    cnt = 0;
    do begin
        @(posedge clk);
        cnt++;
    end while (exp_lens.size() != 0 && cnt < TIMEOUT);
    if (exp_lens.size() != 0) begin
        stop_run("expected receive frames did not arrive before the timeout");
    end
    @(negedge clk);
endtask

// ====================
// receive comparison
// ====================

always @(negedge clk) begin : compare_rx
    logic [4:0] beat;
    logic bad;
    logic good_pulse;
    logic bad_pulse;
    good_pulse = 1'b0;
    bad_pulse = 1'b0;
    if (!rst && rx_axis_tvalid) begin
        if (exp_lens.size() == 0) begin
            stop_run("receive beat arrived while no frame was expected");
        end
        beat = ref_beat(exp_lens[0] - rx_pos);
        bad = exp_bad[0];
        check_value("rx_axis_tkeep", 32'(rx_axis_tkeep), 32'(beat[3:0]));
        check_value("rx_axis_tlast", 32'(rx_axis_tlast), 32'(beat[4]));
        for (int i = 0; i < 4; i++) begin
            if (beat[i]) begin
                check_value("rx_axis_tdata", 32'(rx_axis_tdata[8*i +: 8]),
                            32'(exp_bytes.pop_front()));
            end
        end
        rx_pos = rx_pos + 4;
        if (beat[4]) begin
            check_value("rx_axis_tuser", 32'(rx_axis_tuser), 32'(bad));
            good_pulse = !bad;
            bad_pulse = bad;
            good_cnt = good_cnt + int'(!bad);
            bad_cnt = bad_cnt + int'(bad);
            void'(exp_lens.pop_front());
            void'(exp_bad.pop_front());
            rx_pos = 0;
        end
    end
    if (!rst) begin
        check_value("stat_rx_pkt_good", 32'(stat_rx_pkt_good), 32'(good_pulse));
        check_value("stat_rx_pkt_bad", 32'(stat_rx_pkt_bad), 32'(bad_pulse));
    end
end

always @(negedge clk) begin
    if (!rst && stat_tx_err_underflow) begin
        underflow_cnt++;
    end
    if (!rst && stat_rx_err_preamble) begin
        preamble_cnt++;
    end
    if (!rst && tx_start_packet) begin
        tx_start_cnt++;
    end
    if (!rst && stat_tx_pkt_good) begin
        tx_good_cnt++;
    end
    if (!rst && rx_start_packet) begin
        rx_start_cnt++;
    end
end

// ====================
// test sequence
// ====================

initial begin
    int len;
    int gap;
    int cnt;
    rst = 1'b1;
    loop_sel = 1'b0;
    tx_axis_tdata = '0;
    tx_axis_tkeep = '0;
    tx_axis_tvalid = 1'b0;
    tx_axis_tlast = 1'b0;
    tx_pause_req = 1'b0;
    drv_rxd = {4{eth_xgmii_pkg::XGMII_IDLE}};
    drv_rxc = 4'hf;
    lfsr_state = 32'd84917;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    check_value("xgmii_txd", xgmii_txd, {4{eth_xgmii_pkg::XGMII_IDLE}});
    check_value("xgmii_txc", 32'(xgmii_txc), 32'hf);
    check_value("tx_axis_tready", 32'(tx_axis_tready), 32'h0);
    check_value("rx_axis_tvalid", 32'(rx_axis_tvalid), 32'h0);
    check_value("tx_pause_ack", 32'(tx_pause_ack), 32'h0);

    // random frames through loopback.
    loop_sel = 1'b1;
    for (int f = 0; f < 12; f++) begin
        len = 1 + int'(lfsr_bits(6));
        gap = int'(lfsr_bits(3));
        send_frame(len, -1);
        repeat (gap) @(negedge clk);
    end
    wait_rx_done();
    check_value("good frame count", good_cnt, 12);
    check_value("tx_start_packet count", tx_start_cnt, 12);
    check_value("stat_tx_pkt_good count", tx_good_cnt, 12);
    check_value("rx_start_packet count", rx_start_cnt, 12);

    // stall before the third beat, then a clean frame.
    send_frame(24, 2);
    send_frame(1 + int'(lfsr_bits(6)), -1);
    wait_rx_done();
    check_value("stat_tx_err_underflow count", underflow_cnt, 1);
    check_value("bad frame count", bad_cnt, 1);
    check_value("stat_tx_pkt_good count", tx_good_cnt, 13);

    // pause held while a frame waits.
    tx_pause_req = 1'b1;
    cnt = 0;
    do begin
        @(negedge clk);
        cnt++;
    end while (!tx_pause_ack && cnt < TIMEOUT);
    if (!tx_pause_ack) begin
        stop_run("pause request was not acknowledged before the timeout");
    end
    fork
        send_frame(1 + int'(lfsr_bits(6)), -1);
        begin
            repeat (30) begin
                @(negedge clk);
                check_value("tx_start_packet", 32'(tx_start_packet), 32'h0);
                check_value("tx_pause_ack", 32'(tx_pause_ack), 32'h1);
            end
            tx_pause_req = 1'b0;
        end
    join
    wait_rx_done();
    check_value("good frame count", good_cnt, 14);

    // wrong sfd is dropped, the next frame gets through.
    loop_sel = 1'b0;
    drive_rx_frame(8, eth_xgmii_pkg::ETH_SFD ^ 8'h01);
    check_value("stat_rx_err_preamble count", preamble_cnt, 1);
    drive_rx_frame(1 + int'(lfsr_bits(6)), eth_xgmii_pkg::ETH_SFD);
    wait_rx_done();
    check_value("good frame count", good_cnt, 15);
    check_value("bad frame count", bad_cnt, 1);
    check_value("tx_start_packet count", tx_start_cnt, 15);
    check_value("stat_tx_pkt_good count", tx_good_cnt, 14);
    check_value("rx_start_packet count", rx_start_cnt, 17);

    $display("NO ERRORS");
    $finish;
end

endmodule

// ==== bench/eth_mac_checker.sv ====
// Sampled on the rising clock of the single domain; reset is synchronous and active high.
module eth_mac_checker (
    input logic                         clk,
    input logic                         rst,
    input logic                         tx_axis_tready,
    input logic                         tx_pause_ack,
    input eth_xgmii_pkg::xgmii_data_t   xgmii_txd,
    input eth_xgmii_pkg::xgmii_ctrl_t   xgmii_txc,
    input logic                         rx_axis_tvalid,
    input logic                         rx_axis_tlast,
    input logic                         rx_axis_tuser
);

// no frame may start while transmit is paused.
no_start_paused: assert property (
    @(posedge clk) disable iff (rst)
    tx_pause_ack |-> !(xgmii_txc[0] && xgmii_txd[7:0] == eth_xgmii_pkg::XGMII_START)
) else $error("start character sent while pause is acknowledged");

// encoder holds off the source for the whole reset.
ready_low_in_reset: assert property (
    @(posedge clk) rst && $past(rst) |-> !tx_axis_tready
) else $error("tx_axis_tready high during reset");

// error flag only on the closing beat.
tuser_only_last: assert property (
    @(posedge clk) disable iff (rst)
    rx_axis_tvalid && rx_axis_tuser |-> rx_axis_tlast
) else $error("rx_axis_tuser high on a beat without rx_axis_tlast");

endmodule

// ==== rtl/eth_mac_32.sv ====
// Single clock for both directions; receive stream has no back-pressure and must always be taken.
module eth_mac_32 #(
    parameter int IFG_WORDS = eth_mac_pkg::IFG_WORDS_DEFAULT
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst,

    // transmit stream.
    input  wire logic [eth_xgmii_pkg::DATA_W-1:0]       tx_axis_tdata,
    input  wire logic [eth_xgmii_pkg::LANES-1:0]        tx_axis_tkeep,
    input  wire logic                                   tx_axis_tvalid,
    output logic                                        tx_axis_tready,
    input  wire logic                                   tx_axis_tlast,

    // receive stream.
    output logic [eth_xgmii_pkg::DATA_W-1:0]            rx_axis_tdata,
    output logic [eth_xgmii_pkg::LANES-1:0]             rx_axis_tkeep,
    output logic                                        rx_axis_tvalid,
    output logic                                        rx_axis_tlast,
    output logic                                        rx_axis_tuser,

    // xgmii.
    output logic [eth_xgmii_pkg::DATA_W-1:0]            xgmii_txd,
    output logic [eth_xgmii_pkg::CTRL_W-1:0]            xgmii_txc,
    input  wire logic [eth_xgmii_pkg::DATA_W-1:0]       xgmii_rxd,
    input  wire logic [eth_xgmii_pkg::CTRL_W-1:0]       xgmii_rxc,

    // pause.
    input  wire logic                                   tx_pause_req,
    output logic                                        tx_pause_ack,

    // status pulses.
    output logic                                        tx_start_packet,
    output logic                                        stat_tx_pkt_good,
    output logic                                        stat_tx_err_underflow,
    output logic                                        rx_start_packet,
    output logic                                        stat_rx_pkt_good,
    output logic                                        stat_rx_pkt_bad,
    output logic                                        stat_rx_err_preamble
);

mac_stream_if tx_stream ();

tx_pause_gate gate0 (
    .clk(clk),
    .rst(rst),
    .in_tdata(tx_axis_tdata),
    .in_tkeep(tx_axis_tkeep),
    .in_tvalid(tx_axis_tvalid),
    .in_tlast(tx_axis_tlast),
    .in_tready(tx_axis_tready),
    .out(tx_stream),
    .tx_pause_req(tx_pause_req),
    .tx_pause_ack(tx_pause_ack)
);

xgmii_tx_32 #(
    .IFG_WORDS(IFG_WORDS)
) tx0 (
    .clk(clk),
    .rst(rst),
    .tx(tx_stream),
    .xgmii_txd(xgmii_txd),
    .xgmii_txc(xgmii_txc),
    .tx_start_packet(tx_start_packet),
    .stat_tx_pkt_good(stat_tx_pkt_good),
    .stat_tx_err_underflow(stat_tx_err_underflow)
);

xgmii_rx_32 rx0 (
    .clk(clk),
    .rst(rst),
    .xgmii_rxd(xgmii_rxd),
    .xgmii_rxc(xgmii_rxc),
    .rx_axis_tdata(rx_axis_tdata),
    .rx_axis_tkeep(rx_axis_tkeep),
    .rx_axis_tvalid(rx_axis_tvalid),
    .rx_axis_tlast(rx_axis_tlast),
    .rx_axis_tuser(rx_axis_tuser),
    .rx_start_packet(rx_start_packet),
    .stat_rx_pkt_good(stat_rx_pkt_good),
    .stat_rx_pkt_bad(stat_rx_pkt_bad),
    .stat_rx_err_preamble(stat_rx_err_preamble)
);

endmodule

// ==== rtl/xgmii_rx_32.sv ====
// Start accepted in lane 0 only; no FCS check, frames without data bytes are not delivered.
module xgmii_rx_32 (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire eth_xgmii_pkg::xgmii_data_t         xgmii_rxd,
    input  wire eth_xgmii_pkg::xgmii_ctrl_t         xgmii_rxc,
    output eth_xgmii_pkg::xgmii_data_t              rx_axis_tdata,
    output logic [eth_xgmii_pkg::LANES-1:0]         rx_axis_tkeep,
    output logic                                    rx_axis_tvalid,
    output logic                                    rx_axis_tlast,
    output logic                                    rx_axis_tuser,
    output logic                                    rx_start_packet,
    output logic                                    stat_rx_pkt_good,
    output logic                                    stat_rx_pkt_bad,
    output logic                                    stat_rx_err_preamble
);

eth_mac_pkg::rx_state_t state;

eth_xgmii_pkg::xgmii_data_t hold_d;
logic [eth_xgmii_pkg::LANES-1:0] hold_k;
logic hold_v;
logic hold_l;
logic frame_err;
logic pre_ok;

logic [eth_xgmii_pkg::LANES-1:0] term_vec;
logic [eth_xgmii_pkg::LANES-1:0] err_vec;
logic [eth_xgmii_pkg::LANES-1:0] data_mask;
logic has_term;
logic cur_err;
logic is_start;
logic start_tail_ok;
logic sfd_ok;

// lane decode; data_mask covers lanes before the first terminate.
always_comb begin
    has_term = 1'b0;
    for (int i = 0; i < eth_xgmii_pkg::LANES; i++) begin
        term_vec[i] = xgmii_rxc[i] && xgmii_rxd[8*i +: 8] == eth_xgmii_pkg::XGMII_TERM;
        err_vec[i] = xgmii_rxc[i] && xgmii_rxd[8*i +: 8] == eth_xgmii_pkg::XGMII_ERROR;
        if (term_vec[i]) begin
            has_term = 1'b1;
        end
        data_mask[i] = !has_term;
    end
    cur_err = |(err_vec & data_mask);
end

assign is_start = xgmii_rxc[0] && xgmii_rxd[7:0] == eth_xgmii_pkg::XGMII_START;
assign start_tail_ok = xgmii_rxc[3:1] == 3'b000 &&
                       xgmii_rxd[31:8] == {3{eth_xgmii_pkg::ETH_PRE}};
assign sfd_ok = xgmii_rxc == '0 &&
                xgmii_rxd == {eth_xgmii_pkg::ETH_SFD, {3{eth_xgmii_pkg::ETH_PRE}}};

always_ff @(posedge clk) begin
    if (rst) begin
        state <= eth_mac_pkg::RX_IDLE;
        hold_v <= 1'b0;
        hold_l <= 1'b0;
        frame_err <= 1'b0;
        pre_ok <= 1'b0;
        rx_axis_tvalid <= 1'b0;
        rx_axis_tlast <= 1'b0;
        rx_axis_tuser <= 1'b0;
        rx_start_packet <= 1'b0;
        stat_rx_pkt_good <= 1'b0;
        stat_rx_pkt_bad <= 1'b0;
        stat_rx_err_preamble <= 1'b0;
    end else begin
        rx_axis_tvalid <= 1'b0;
        rx_start_packet <= is_start;
        stat_rx_pkt_good <= 1'b0;
        stat_rx_pkt_bad <= 1'b0;
        stat_rx_err_preamble <= 1'b0;

        // short last word left over from a terminate in lanes 1..3.
        if (hold_v && hold_l) begin
            rx_axis_tvalid <= 1'b1;
            rx_axis_tdata <= hold_d;
            rx_axis_tkeep <= hold_k;
            rx_axis_tlast <= 1'b1;
            rx_axis_tuser <= frame_err;
            stat_rx_pkt_good <= !frame_err;
            stat_rx_pkt_bad <= frame_err;
            hold_v <= 1'b0;
            hold_l <= 1'b0;
        end

        case (state)
            eth_mac_pkg::RX_IDLE: begin
                if (is_start) begin
                    pre_ok <= start_tail_ok;
                    state <= eth_mac_pkg::RX_PREAMBLE;
                end
            end
            eth_mac_pkg::RX_PREAMBLE: begin
                if (pre_ok && sfd_ok) begin
                    frame_err <= 1'b0;
                    state <= eth_mac_pkg::RX_DATA;
                end else begin
                    stat_rx_err_preamble <= 1'b1;
                    state <= has_term ? eth_mac_pkg::RX_IDLE : eth_mac_pkg::RX_DROP;
                end
            end
            eth_mac_pkg::RX_DATA: begin
                // a new word releases the held one; terminate in lane 0 makes it last.
                if (hold_v) begin
                    rx_axis_tvalid <= 1'b1;
                    rx_axis_tdata <= hold_d;
                    rx_axis_tkeep <= hold_k;
                    rx_axis_tlast <= term_vec[0];
                    rx_axis_tuser <= term_vec[0] && frame_err;
                    stat_rx_pkt_good <= term_vec[0] && !frame_err;
                    stat_rx_pkt_bad <= term_vec[0] && frame_err;
                end
                frame_err <= frame_err || cur_err;
                hold_d <= xgmii_rxd;
                hold_k <= data_mask;
                hold_v <= |data_mask;
                hold_l <= has_term;
                if (has_term) begin
                    state <= eth_mac_pkg::RX_IDLE;
                end
            end
            default: begin
                if (has_term) begin
                    state <= eth_mac_pkg::RX_IDLE;
                end
            end
        endcase
    end
end

endmodule

// ==== rtl/xgmii_tx_32.sv ====
// No FCS, padding or deficit idle; IFG_WORDS >= 1, and an underflow drains the rest of the frame.
module xgmii_tx_32 #(
    parameter int IFG_WORDS = 3
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    mac_stream_if.snk                   tx,
    output eth_xgmii_pkg::xgmii_data_t  xgmii_txd,
    output eth_xgmii_pkg::xgmii_ctrl_t  xgmii_txc,
    output logic                        tx_start_packet,
    output logic                        stat_tx_pkt_good,
    output logic                        stat_tx_err_underflow
);

localparam int CNT_W = $clog2(IFG_WORDS + 1);
localparam eth_xgmii_pkg::xgmii_data_t IDLE_WORD = {eth_xgmii_pkg::LANES{eth_xgmii_pkg::XGMII_IDLE}};

eth_mac_pkg::tx_state_t state;
logic [CNT_W-1:0] ifg_cnt;
logic drop;

eth_xgmii_pkg::xgmii_data_t beat_d;
eth_xgmii_pkg::xgmii_ctrl_t beat_c;

assign tx.tready = (state == eth_mac_pkg::TX_DATA);

// ====================
// lane mapping
// ====================

// unused lanes get terminate in the first one, idles after it.
always_comb begin
    logic prev_keep;
    prev_keep = 1'b1;
    for (int i = 0; i < eth_xgmii_pkg::LANES; i++) begin
        if (tx.tkeep[i]) begin
            beat_d[8*i +: 8] = tx.tdata[8*i +: 8];
            beat_c[i] = 1'b0;
        end else if (prev_keep) begin
            beat_d[8*i +: 8] = eth_xgmii_pkg::XGMII_TERM;
            beat_c[i] = 1'b1;
        end else begin
            beat_d[8*i +: 8] = eth_xgmii_pkg::XGMII_IDLE;
            beat_c[i] = 1'b1;
        end
        prev_keep = tx.tkeep[i];
    end
end

// ====================
// encoder
// ====================

always_ff @(posedge clk) begin
    if (rst) begin
        state <= eth_mac_pkg::TX_IDLE;
        ifg_cnt <= '0;
        drop <= 1'b0;
        xgmii_txd <= IDLE_WORD;
        xgmii_txc <= '1;
        tx_start_packet <= 1'b0;
        stat_tx_pkt_good <= 1'b0;
        stat_tx_err_underflow <= 1'b0;
    end else begin
        xgmii_txd <= IDLE_WORD;
        xgmii_txc <= '1;
        tx_start_packet <= 1'b0;
        stat_tx_pkt_good <= 1'b0;
        stat_tx_err_underflow <= 1'b0;
        case (state)
            eth_mac_pkg::TX_IDLE: begin
                if (tx.tvalid) begin
                    xgmii_txd <= {{3{eth_xgmii_pkg::ETH_PRE}}, eth_xgmii_pkg::XGMII_START};
                    xgmii_txc <= 4'b0001;
                    tx_start_packet <= 1'b1;
                    state <= eth_mac_pkg::TX_PREAMBLE;
                end
            end
            eth_mac_pkg::TX_PREAMBLE: begin
                xgmii_txd <= {eth_xgmii_pkg::ETH_SFD, {3{eth_xgmii_pkg::ETH_PRE}}};
                xgmii_txc <= '0;
                drop <= 1'b0;
                state <= eth_mac_pkg::TX_DATA;
            end
            eth_mac_pkg::TX_DATA: begin
                if (drop) begin
                    // discard what is left of an underflowed frame.
                    if (tx.tvalid && tx.tlast) begin
                        ifg_cnt <= '0;
                        state <= eth_mac_pkg::TX_IFG;
                    end
                end else if (tx.tvalid) begin
                    xgmii_txd <= beat_d;
                    xgmii_txc <= beat_c;
                    if (tx.tlast && &tx.tkeep) begin
                        state <= eth_mac_pkg::TX_TERM;
                    end else if (tx.tlast) begin
                        stat_tx_pkt_good <= 1'b1;
                        ifg_cnt <= '0;
                        state <= eth_mac_pkg::TX_IFG;
                    end
                end else begin
                    xgmii_txd <= {eth_xgmii_pkg::LANES{eth_xgmii_pkg::XGMII_ERROR}};
                    stat_tx_err_underflow <= 1'b1;
                    drop <= 1'b1;
                    state <= eth_mac_pkg::TX_TERM;
                end
            end
            eth_mac_pkg::TX_TERM: begin
                xgmii_txd <= {{3{eth_xgmii_pkg::XGMII_IDLE}}, eth_xgmii_pkg::XGMII_TERM};
                stat_tx_pkt_good <= !drop;
                ifg_cnt <= '0;
                state <= drop ? eth_mac_pkg::TX_DATA : eth_mac_pkg::TX_IFG;
            end
            default: begin
                ifg_cnt <= ifg_cnt + 1'b1;
                if (ifg_cnt == CNT_W'(IFG_WORDS - 1)) begin
                    state <= eth_mac_pkg::TX_IDLE;
                end
            end
        endcase
    end
end

endmodule

// ==== rtl/tx_pause_gate.sv ====
// Pause takes effect only between frames; a frame counts as started once tvalid is offered.
module tx_pause_gate (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire eth_xgmii_pkg::xgmii_data_t         in_tdata,
    input  wire logic [eth_xgmii_pkg::LANES-1:0]    in_tkeep,
    input  wire logic                               in_tvalid,
    input  wire logic                               in_tlast,
    output logic                                    in_tready,
    mac_stream_if.src                               out,
    input  wire logic                               tx_pause_req,
    output logic                                    tx_pause_ack
);

eth_mac_pkg::gate_state_t state;
logic blocked;

// block while paused, or while a request is pending between frames.
assign blocked = (state == eth_mac_pkg::GATE_PAUSED) ||
                 (state == eth_mac_pkg::GATE_PASS && tx_pause_req);

assign out.tdata = in_tdata;
assign out.tkeep = in_tkeep;
assign out.tlast = in_tlast;
assign out.tvalid = in_tvalid && !blocked;
assign in_tready = out.tready && !blocked;

assign tx_pause_ack = (state == eth_mac_pkg::GATE_PAUSED);

always_ff @(posedge clk) begin
    if (rst) begin
        state <= eth_mac_pkg::GATE_PASS;
    end else begin
        case (state)
            eth_mac_pkg::GATE_PASS: begin
                if (tx_pause_req) begin
                    state <= eth_mac_pkg::GATE_PAUSED;
                end else if (in_tvalid && !(out.tready && in_tlast)) begin
                    // encoder commits to the frame as soon as it sees tvalid.
                    state <= eth_mac_pkg::GATE_FRAME;
                end
            end
            eth_mac_pkg::GATE_FRAME: begin
                if (in_tvalid && out.tready && in_tlast) begin
                    state <= tx_pause_req ? eth_mac_pkg::GATE_PAUSED : eth_mac_pkg::GATE_PASS;
                end
            end
            default: begin
                if (!tx_pause_req) begin
                    state <= eth_mac_pkg::GATE_PASS;
                end
            end
        endcase
    end
end

endmodule

// ==== rtl/mac_stream_if.sv ====
// Byte stream with ready; tkeep contiguous from lane 0 and partial only on the tlast beat.
interface mac_stream_if;

    eth_xgmii_pkg::xgmii_data_t tdata;
    logic [eth_xgmii_pkg::LANES-1:0] tkeep;
    logic tvalid;
    logic tready;
    logic tlast;

    // frame source side.
    modport src (
        output tdata, tkeep, tvalid, tlast,
        input  tready
    );

    // frame sink side.
    modport snk (
        input  tdata, tkeep, tvalid, tlast,
        output tready
    );

endinterface

// ==== rtl/eth_mac_pkg.sv ====
// MAC-side states and gap timing for a single clock domain; IFG counted in whole words only.
package eth_mac_pkg;

    // ====================
    // state machines
    // ====================

    // transmit encoder.
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_DATA,
        TX_TERM,
        TX_IFG
    } tx_state_t;

    // receive decoder.
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DROP
    } rx_state_t;

    // pause gate tracking of frame boundaries.
    typedef enum logic [1:0] {
        GATE_PASS,
        GATE_FRAME,
        GATE_PAUSED
    } gate_state_t;

    // all-idle words after the terminate word.
    localparam int IFG_WORDS_DEFAULT = 3;

endpackage

// ==== rtl/eth_xgmii_pkg.sv ====
// 32-bit XGMII only; lane 0 holds the earliest byte, txc/rxc bit set marks a control character.
package eth_xgmii_pkg;

    // ====================
    // widths
    // ====================

    // byte lanes per xgmii word.
    localparam int LANES = 4;
    localparam int DATA_W = 32;
    localparam int CTRL_W = 4;

    typedef logic [DATA_W-1:0] xgmii_data_t;

    // one bit per lane, set for a control character.
    typedef logic [CTRL_W-1:0] xgmii_ctrl_t;

    // ====================
    // line codes
    // ====================

    localparam logic [7:0] XGMII_IDLE = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // preamble bytes that follow the start character.
    localparam logic [7:0] ETH_PRE = 8'h55;
    localparam logic [7:0] ETH_SFD = 8'hd5;

endpackage
